/* Makefile */
# Verilator build, run, lint and clean for the config slave

TOP := tb_ecfg

all: run

build:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "All tests passed" sim.log || (echo "simulation FAILED" && exit 1)

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* cfg_req_fifo.sv */
// circular request buffer with full / not-empty flags
`default_nettype none

module cfg_req_fifo #(
  parameter int DEPTH = 4 // power of two
) (
  input  wire logic               clk,
  input  wire logic               hard_reset,
  // write side
  input  wire logic               push,
  input  wire ecfg_pkg::cfg_req_t push_req,
  // read side
  input  wire logic               pop,
  output ecfg_pkg::cfg_req_t      head_req,
  output logic                    not_empty,
  output logic                    full
);

  import ecfg_pkg::*;

  localparam int AW = $clog2(DEPTH); // index width

  // ############################################################
  // storage and pointers
  // ############################################################

  cfg_req_t      mem [DEPTH];     // request payload slots
  logic [AW:0]   wr_ptr;          // extra msb tells full from empty
  logic [AW:0]   rd_ptr;
  logic          do_push;
  logic          do_pop;

  // flags from pointer compare
  assign not_empty = (wr_ptr != rd_ptr);
  assign full      = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]); // wrapped once

  assign do_push = push & ~full;      // push into a full fifo is dropped
  assign do_pop  = pop & not_empty;   // same for pop when empty

  // head is a plain read of the oldest slot
  assign head_req = mem[rd_ptr[AW-1:0]];

  // ############################################################
  // pointer update
  // ############################################################

  always_ff @(posedge clk) begin
    if (hard_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1; // independent, so push+pop both move
    end
  end

  // data write, head visible the cycle after
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr[AW-1:0]] <= push_req;
  end

endmodule : cfg_req_fifo

`default_nettype wire

/* ecfg_clocks.sv */
// reset / clock / coreid config registers, address decode
// and registered read-response packet
`default_nettype none

module ecfg_clocks #(
  parameter int RFAW = 6 // register index width
) (
  input  wire logic                  clk,
  input  wire logic                  hard_reset, // only reset of these regs
  // request from fifo head
  input  wire ecfg_pkg::cfg_req_t    head_req,
  input  wire logic                  not_empty,
  output logic                       pop,
  // read-response channel
  output logic                       rr_access,
  output ecfg_pkg::emesh_packet_t    rr_packet,
  input  wire logic                  rr_wait,
  // config outputs
  output logic                       soft_reset,
  output ecfg_pkg::ecfg_clk_t        ecfg_clk_settings,
  output logic [11:0]                ecfg_coreid
);

  import ecfg_pkg::*;

  // ############################################################
  // decode
  // ############################################################

  logic [RFAW-1:0] reg_idx;
  logic            wr_req;
  logic            rd_req;
  logic            slot_free;
  logic            rd_pop;
  logic            reset_write;
  logic            clk_write;
  logic            coreid_write;
  logic [31:0]     rd_data;

  assign reg_idx = head_req.reg_addr[RFAW+1:2]; // word index

  assign wr_req = not_empty &  head_req.write;
  assign rd_req = not_empty & ~head_req.write;

  // response reg empty, or emptied this edge
  assign slot_free = ~rr_access | ~rr_wait;
  assign rd_pop    = rd_req & slot_free; // stalled read blocks the queue

  // writes never wait
  assign pop = wr_req | rd_pop;

  // per-register write enables
  assign reset_write  = wr_req & (reg_idx == RFAW'(E_RESET));
  assign clk_write    = wr_req & (reg_idx == RFAW'(E_CLK));
  assign coreid_write = wr_req & (reg_idx == RFAW'(E_COREID));
  // version and unmapped indices: no enable, write ignored

  // ############################################################
  // registers
  // ############################################################

  always_ff @(posedge clk) begin
    if (hard_reset) begin
      soft_reset        <= 1'b0;
      ecfg_clk_settings <= '0;
      ecfg_coreid       <= '0;
    end else begin
      if (reset_write)
        soft_reset <= head_req.data.reset_view.soft_reset; // bit 0
      if (clk_write)
        ecfg_clk_settings <= head_req.data.clk_view.clk; // low 16 bits
      if (coreid_write)
        ecfg_coreid <= head_req.data.raw[11:0];
    end
  end

  // ############################################################
  // read mux
  // ############################################################

  always_comb begin
    rd_data = '0; // unmapped reads return zero
    case (reg_idx)
      RFAW'(E_RESET):   rd_data = {31'd0, soft_reset};
      RFAW'(E_CLK):     rd_data = {16'd0, ecfg_clk_settings};
      RFAW'(E_COREID):  rd_data = {20'd0, ecfg_coreid};
      RFAW'(E_VERSION): rd_data = {16'd0, ECFG_VERSION}; // read only
      default:          rd_data = '0;
    endcase
  end

  // ############################################################
  // response register
  // ############################################################

  // access flag, set on a read pop, dropped once taken
  always_ff @(posedge clk) begin
    if (hard_reset)
      rr_access <= 1'b0;
    else if (rd_pop)
      rr_access <= 1'b1;         // new answer, possibly back to back
    else if (rr_access & ~rr_wait)
      rr_access <= 1'b0;         // taken, slot empty
  end

  // packet held while rr_wait, only loads with a free slot
  always_ff @(posedge clk) begin
    if (rd_pop) begin
      rr_packet.write    <= 1'b1;
      rr_packet.datamode <= 2'd0;
      rr_packet.ctrlmode <= 5'd0;
      rr_packet.dstaddr  <= head_req.reply_addr; // back to requester
      rr_packet.data     <= rd_data;
      rr_packet.srcaddr  <= head_req.reg_addr;   // register that answered
    end
  end

endmodule : ecfg_clocks

`default_nettype wire

/* ecfg_pkg.sv */
// shared types for the config slave: mesh packet, request, data views
// register indices and version constant
`default_nettype none

package ecfg_pkg;

  // ############################################################
  // mesh packet, both channels
  // ############################################################

  typedef struct packed {
    logic        write;     // 1 = write / read-response
    logic [1:0]  datamode;  // carried, not used
    logic [4:0]  ctrlmode;  // carried, not used
    logic [31:0] dstaddr;
    logic [31:0] data;
    logic [31:0] srcaddr;
  } emesh_packet_t;         // 104 bits

  // ############################################################
  // config data word and its views
  // ############################################################

  // pll settings, also the ecfg_clk_settings output type
  typedef struct packed {
    logic [3:0] cclk_div;
    logic [3:0] cclk_phase;
    logic [3:0] lclk_div;
    logic [3:0] lclk_phase;
  } ecfg_clk_t;

  typedef struct packed {
    logic [15:0] unused;
    ecfg_clk_t   clk;       // low half
  } cfg_clk_view_t;

  typedef struct packed {
    logic [30:0] unused;
    logic        soft_reset; // bit 0 only
  } cfg_reset_view_t;

  // one word, decoded per target register
  typedef union packed {
    logic [31:0]     raw;
    cfg_clk_view_t   clk_view;
    cfg_reset_view_t reset_view;
  } cfg_data_u;

  // ############################################################
  // unpacked register request
  // ############################################################

  typedef struct packed {
    logic        write;
    logic [31:0] reg_addr;   // full dstaddr of the access
    cfg_data_u   data;
    logic [31:0] reply_addr; // srcaddr, where a read answer goes
  } cfg_req_t;               // 97 bits

  // register map, index = addr[RFAW+1:2]
  localparam int unsigned E_RESET   = 0;
  localparam int unsigned E_CLK     = 1;
  localparam int unsigned E_COREID  = 2;
  localparam int unsigned E_VERSION = 3;

  // read-only version value
  localparam logic [15:0] ECFG_VERSION = 16'h0104;

endpackage : ecfg_pkg

`default_nettype wire

/* ecfg_properties.sv */
// handshake and fifo assertions, bound into ecfg_top
`default_nettype none

module ecfg_properties (
  input wire logic                    clk,
  input wire logic                    hard_reset,
  input wire logic                    rr_access,
  input wire ecfg_pkg::emesh_packet_t rr_packet,
  input wire logic                    rr_wait,
  input wire logic                    req_valid, // decoder push
  input wire logic                    fifo_full
);

  // ############################################################
  // response channel
  // ############################################################

  // stalled response keeps its packet
  a_rr_stable: assert property (@(posedge clk) disable iff (hard_reset)
    (rr_access && rr_wait) |=> $stable(rr_packet))
    else $error("rr_packet changed while rr_wait held it");

  // and stays offered
  a_rr_held: assert property (@(posedge clk) disable iff (hard_reset)
    (rr_access && rr_wait) |=> rr_access)
    else $error("rr_access dropped before the response was taken");

  // clean after reset
  a_rr_reset: assert property (@(posedge clk)
    hard_reset |=> !rr_access)
    else $error("rr_access high right after hard_reset");

  // ############################################################
  // request fifo
  // ############################################################

  a_no_push_full: assert property (@(posedge clk) disable iff (hard_reset)
    !(req_valid && fifo_full))
    else $error("push into a full request fifo");

endmodule : ecfg_properties

bind ecfg_top ecfg_properties u_props (
  .clk        (clk),
  .hard_reset (hard_reset),
  .rr_access  (rr_access),
  .rr_packet  (rr_packet),
  .rr_wait    (rr_wait),
  .req_valid  (req_valid),
  .fifo_full  (fifo_full)
);

`default_nettype wire

/* ecfg_top.sv */
// config slave top: packet decoder, request fifo, register block
`default_nettype none

module ecfg_top #(
  parameter int DEPTH = 4, // request fifo depth
  parameter int RFAW  = 6  // register index width
) (
  input  wire logic                    clk,
  input  wire logic                    hard_reset,
  // register access packets in
  input  wire logic                    txwr_access,
  input  wire ecfg_pkg::emesh_packet_t txwr_packet,
  output logic                         txwr_wait,
  // read responses out
  output logic                         rr_access,
  output ecfg_pkg::emesh_packet_t      rr_packet,
  input  wire logic                    rr_wait,
  // to the rest of the chip
  output logic                         soft_reset,
  output ecfg_pkg::ecfg_clk_t          ecfg_clk_settings,
  output logic [11:0]                  ecfg_coreid
);

  import ecfg_pkg::*;

  logic     req_valid; // decoder push
  cfg_req_t req;
  logic     fifo_full;
  cfg_req_t head_req;  // oldest pending request
  logic     not_empty;
  logic     pop;

  // producer
  emesh_packet_decode u_decode (
    .txwr_access (txwr_access),
    .txwr_packet (txwr_packet),
    .txwr_wait   (txwr_wait),
    .req_valid   (req_valid),
    .req         (req),
    .fifo_full   (fifo_full)
  );

  // buffer
  cfg_req_fifo #(
    .DEPTH (DEPTH)
  ) u_fifo (
    .clk        (clk),
    .hard_reset (hard_reset),
    .push       (req_valid),
    .push_req   (req),
    .pop        (pop),
    .head_req   (head_req),
    .not_empty  (not_empty),
    .full       (fifo_full)
  );

  // consumer
  ecfg_clocks #(
    .RFAW (RFAW)
  ) u_clocks (
    .clk               (clk),
    .hard_reset        (hard_reset),
    .head_req          (head_req),
    .not_empty         (not_empty),
    .pop               (pop),
    .rr_access         (rr_access),
    .rr_packet         (rr_packet),
    .rr_wait           (rr_wait),
    .soft_reset        (soft_reset),
    .ecfg_clk_settings (ecfg_clk_settings),
    .ecfg_coreid       (ecfg_coreid)
  );

endmodule : ecfg_top

`default_nettype wire

/* emesh_packet_decode.sv */
// mesh packet to register request unpacking
// push gating and wait back to the sender
`default_nettype none

module emesh_packet_decode (
  // request channel from the mesh
  input  wire logic                  txwr_access,
  input  wire ecfg_pkg::emesh_packet_t txwr_packet,
  output logic                       txwr_wait,
  // toward the request fifo
  output logic                       req_valid,
  output ecfg_pkg::cfg_req_t         req,
  input  wire logic                  fifo_full
);

  // ############################################################
  // handshake
  // ############################################################

  // sender holds the packet while wait is high, so a full fifo
  // simply stalls it; nothing dropped, nothing pushed twice
  assign txwr_wait = fifo_full;

  // accept == push, same condition the sender sees
  assign req_valid = txwr_access & ~fifo_full;

  // ############################################################
  // field unpacking
  // ############################################################

  always_comb begin
    req.write      = txwr_packet.write;   // 1 = write, 0 = read
    req.reg_addr   = txwr_packet.dstaddr; // register select lives here
    req.data.raw   = txwr_packet.data;    // views picked later per reg
    req.reply_addr = txwr_packet.srcaddr; // answer goes back here
    // datamode / ctrlmode dropped, single word accesses only
  end

endmodule : emesh_packet_decode

`default_nettype wire

/* sources.f */
ecfg_pkg.sv
emesh_packet_decode.sv
cfg_req_fifo.sv
ecfg_clocks.sv
ecfg_top.sv
ecfg_properties.sv
tb_ecfg.sv

/* tb_ecfg.sv */
// testbench for the config slave: clock, reset, lfsr stimulus,
// reference model, response checker and cycle limit
`default_nettype none

module tb_ecfg;

  import ecfg_pkg::*;

  localparam int DEPTH      = 4;
  localparam int RFAW       = 6;
  localparam int N_DIRECTED = 12;             // writes, reads, write-then-read
  localparam int N_BP       = DEPTH + 4;      // stalled reads plus tail
  localparam int N_RANDOM   = 60;
  localparam int N_PACKETS  = N_DIRECTED + N_BP + N_RANDOM;
  localparam int MAX_CYCLES = 20 * N_PACKETS + 200;

  logic          clk = 1'b0;
  logic          hard_reset;
  logic          txwr_access;
  emesh_packet_t txwr_packet;
  logic          txwr_wait;
  logic          rr_access;
  emesh_packet_t rr_packet;
  logic          rr_wait;
  logic          soft_reset;
  ecfg_clk_t     ecfg_clk_settings;
  logic [11:0]   ecfg_coreid;

  // register model and pending responses
  logic          m_soft_reset;
  ecfg_clk_t     m_clk;
  logic [11:0]   m_coreid;
  emesh_packet_t exp_q [$];
  emesh_packet_t exp_pkt;

  logic [31:0]   lfsr_state = 32'h945b_c3b5;
  logic [1:0]    stall_mode;   // 0 none, 1 always, 2 random
  logic          stall_next;
  string         test_name;
  int            errors = 0;
  int            n_checks = 0;
  int            n_responses = 0;
  int            cycles = 0;

  ecfg_top #(
    .DEPTH (DEPTH),
    .RFAW  (RFAW)
  ) UUT (
    .clk               (clk),
    .hard_reset        (hard_reset),
    .txwr_access       (txwr_access),
    .txwr_packet       (txwr_packet),
    .txwr_wait         (txwr_wait),
    .rr_access         (rr_access),
    .rr_packet         (rr_packet),
    .rr_wait           (rr_wait),
    .soft_reset        (soft_reset),
    .ecfg_clk_settings (ecfg_clk_settings),
    .ecfg_coreid       (ecfg_coreid)
  );

  always #4 clk = ~clk; // period 8

  // ############################################################
  // stimulus helpers
  // ############################################################

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic emesh_packet_t make_packet(input logic wr, input logic [5:0] idx,
                                                input logic [31:0] data,
                                                input logic [31:0] src);
    emesh_packet_t p;
    p.write    = wr;
    p.datamode = 2'b10;  // ignored by the slave
    p.ctrlmode = 5'h15;  // same
    p.dstaddr  = 32'h000f_0000 | {24'd0, idx, 2'b00};
    p.data     = data;
    p.srcaddr  = src;
    return p;
  endfunction

  // reference model, applied once per accepted packet
  function automatic void apply_model(input emesh_packet_t pkt);
    logic [RFAW-1:0] idx;
    emesh_packet_t   rsp;
    idx = pkt.dstaddr[RFAW+1:2];
    if (pkt.write) begin
      if (idx == RFAW'(E_RESET))
        m_soft_reset = pkt.data[0];
      else if (idx == RFAW'(E_CLK))
        m_clk = pkt.data[15:0];      // cclk_div in the top nibble
      else if (idx == RFAW'(E_COREID))
        m_coreid = pkt.data[11:0];
    end else begin
      rsp         = '0;
      rsp.write   = 1'b1;
      rsp.dstaddr = pkt.srcaddr;     // answer goes back to the sender
      rsp.srcaddr = pkt.dstaddr;
      if (idx == RFAW'(E_RESET))
        rsp.data = {31'd0, m_soft_reset};
      else if (idx == RFAW'(E_CLK))
        rsp.data = {16'd0, m_clk};
      else if (idx == RFAW'(E_COREID))
        rsp.data = {20'd0, m_coreid};
      else if (idx == RFAW'(E_VERSION))
        rsp.data = {16'd0, ECFG_VERSION};
      exp_q.push_back(rsp);          // unmapped stays zero
    end
  endfunction

  // called 1 after a rising edge, returns 1 after the accepting edge
  task automatic send_packet(input emesh_packet_t pkt);
    txwr_access = 1'b1;
    txwr_packet = pkt;
    @(negedge clk);
    while (txwr_wait)
      @(negedge clk);
    apply_model(pkt); // taken at the coming edge
    @(posedge clk);
    #1;
    txwr_access = 1'b0;
  endtask

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // queue empty and nothing left in the request fifo
  task automatic wait_drained();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0 || UUT.not_empty);
  endtask

  task automatic check_outputs();
    expect_eq("soft_reset", {31'd0, m_soft_reset}, {31'd0, soft_reset});
    expect_eq("clk_settings", {16'd0, m_clk}, {16'd0, ecfg_clk_settings});
    expect_eq("coreid", {20'd0, m_coreid}, {20'd0, ecfg_coreid});
    expect_eq("rr_access", 32'd0, {31'd0, rr_access});
    expect_eq("txwr_wait", 32'd0, {31'd0, txwr_wait});
    expect_eq("pending", 32'd0, exp_q.size());
  endtask

  // ############################################################
  // response channel: stalls and comparison
  // ############################################################

  always @(negedge clk) begin
    if (stall_mode == 2'd2)
      stall_next = rand_bits(1) != 32'd0; // coin flip per cycle
    else
      stall_next = (stall_mode == 2'd1);
  end

  always @(posedge clk) begin
    #1 rr_wait = stall_next;
  end

  // rr_wait is settled here, so this response is taken at the next edge
  always @(negedge clk) begin
    if (!hard_reset && rr_access && !rr_wait) begin
      n_checks++;
      n_responses++; // every handshake, expected or not
      if (exp_q.size() == 0) begin
        errors++;
        $display("response %h arrived with no read pending", rr_packet);
      end else begin
        exp_pkt = exp_q.pop_front();
        if (rr_packet !== exp_pkt) begin
          errors++;
          $display("MISMATCH %s response expected %h actual %h",
                   test_name, exp_pkt, rr_packet);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("run exceeded %0d cycles, traffic never drained", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  // ############################################################
  // test sequence
  // ############################################################

  initial begin
    logic [31:0] r_ctl;
    logic [31:0] r_data;
    logic [31:0] r_src;
    int          resp_base;
    hard_reset   = 1'b1;
    txwr_access  = 1'b0;
    txwr_packet  = '0;
    rr_wait      = 1'b0;
    stall_mode   = 2'd0;
    stall_next   = 1'b0;
    m_soft_reset = 1'b0;
    m_clk        = '0;
    m_coreid     = '0;
    repeat (8) @(posedge clk);
    #1 hard_reset = 1'b0;

    test_name = "reset";
    check_outputs();

    test_name = "writes";
    send_packet(make_packet(1'b1, 6'd0, 32'h0000_0003, 32'h0000_a000));
    send_packet(make_packet(1'b1, 6'd1, 32'hdead_1234, 32'h0000_a004));
    send_packet(make_packet(1'b1, 6'd2, 32'h1234_5abc, 32'h0000_a008));
    send_packet(make_packet(1'b1, 6'd3, 32'hffff_ffff, 32'h0000_a00c));  // read only
    send_packet(make_packet(1'b1, 6'd13, 32'hffff_ffff, 32'h0000_a010)); // unmapped
    wait_drained();
    check_outputs();
    // clock fields straight from 16'h1234
    expect_eq("cclk_div", 32'h1, {28'd0, ecfg_clk_settings.cclk_div});
    expect_eq("cclk_phase", 32'h2, {28'd0, ecfg_clk_settings.cclk_phase});
    expect_eq("lclk_div", 32'h3, {28'd0, ecfg_clk_settings.lclk_div});
    expect_eq("lclk_phase", 32'h4, {28'd0, ecfg_clk_settings.lclk_phase});
    expect_eq("coreid_abs", 32'habc, {20'd0, ecfg_coreid});

    test_name = "reads";
    send_packet(make_packet(1'b0, 6'd0, 32'd0, 32'h0000_b000));
    send_packet(make_packet(1'b0, 6'd1, 32'd0, 32'h0000_b004));
    send_packet(make_packet(1'b0, 6'd2, 32'd0, 32'h0000_b008));
    send_packet(make_packet(1'b0, 6'd3, 32'd0, 32'h0000_b00c));
    send_packet(make_packet(1'b0, 6'd13, 32'd0, 32'h0000_b010));
    send_packet(make_packet(1'b1, 6'd2, 32'h0000_0777, 32'h0000_b014));
    send_packet(make_packet(1'b0, 6'd2, 32'd0, 32'h0000_b018)); // sees 777
    wait_drained();
    check_outputs();

    test_name = "backpressure";
    stall_mode = 2'd1;
    @(posedge clk);
    #1;
    resp_base = n_responses;
    for (int i = 0; i < DEPTH + 1; i++) begin
      if (i == DEPTH)
        expect_eq("wait_early", 32'd0, {31'd0, txwr_wait});
      send_packet(make_packet(1'b0, {4'd0, i[1:0]}, 32'd0, 32'h0000_c000 + i));
    end
    expect_eq("wait_full", 32'd1, {31'd0, txwr_wait});  // one held, DEPTH queued
    expect_eq("stalled", 32'd1, {31'd0, rr_access});
    stall_mode = 2'd0;
    for (int i = 0; i < 3; i++)
      send_packet(make_packet(1'b0, 6'd3, 32'd0, 32'h0000_c100 + i));
    wait_drained();
    expect_eq("responses", resp_base + DEPTH + 4, n_responses);
    check_outputs();

    test_name = "random";
    stall_mode = 2'd2;
    for (int i = 0; i < N_RANDOM; i++) begin
      r_ctl  = rand_bits(5);   // write flag, gap flag, index
      r_data = rand_bits(32);
      r_src  = rand_bits(32);
      send_packet(make_packet(r_ctl[4], {3'd0, r_ctl[2:0]}, r_data, r_src));
      if (r_ctl[3]) begin
        @(posedge clk);
        #1;
      end
    end
    wait_drained();
    stall_mode = 2'd0;
    check_outputs();

    $display("checks %0d  errors %0d  responses %0d", n_checks, errors, n_responses);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule : tb_ecfg

`default_nettype wire
